// File: Bender.yml
package:
  name: mmio_afu

sources:
  - include_dirs:
      - .
    files:
      - mmio_afu_pkg.sv
      - mmio_fabric.sv
      - csr_afu.sv
      - prbs_engine.sv
      - afu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_afu_top.sv

// File: afu_macros.svh
`ifndef AFU_MACROS_SVH
`define AFU_MACROS_SVH

// host MMIO bus geometry
`define MMIO_DATA_W 64
`define MMIO_ADDR_W 18
`define MMIO_BE_W   8

// csr block registers, 64-bit words on even addresses
`define AFU_DFH     18'h00000
`define ID_L        18'h00002
`define ID_H        18'h00004
`define DFH_RSVD    18'h00006
`define ERROR       18'h0000A
`define SCRATCH     18'h0000C

// prbs engine registers
`define PRBS_CTRL   18'h00020
`define PRBS_WORDS  18'h00022
`define PRBS_ERRS   18'h00024

// block windows, both bounds inclusive
`define CSR_BASE    18'h00000
`define CSR_LAST    18'h0001F
`define PRBS_BASE   18'h00020
`define PRBS_LAST   18'h0003F

// accelerator uuid, high half read at ID_H
`define AFU_ID      128'h3f8a6c21_9e4d4b07_a1c57d20_e96b5f34

// byte offset of the next feature header
`define DFH_NEXT_OFFSET 24'h0003FA

`endif

// File: afu_top.sv
`timescale 1ns/1ps
`default_nettype none

module afu_top (
    input  logic                    clk,
    input  logic                    reset,
    input  mmio_afu_pkg::mmio_req_t mmio_req,
    output mmio_afu_pkg::mmio_rsp_t mmio_rsp
);
    import mmio_afu_pkg::*;

    mmio_req_t csr_req;
    mmio_req_t prbs_req;
    mmio_rsp_t csr_rsp;
    mmio_rsp_t prbs_rsp;
    logic      unmapped_evt;
    logic      mismatch_evt;

    // decode and response merge
    mmio_fabric fabric_i (
        .clk          (clk),
        .reset        (reset),
        .host_req     (mmio_req),
        .host_rsp     (mmio_rsp),
        .csr_req      (csr_req),
        .prbs_req     (prbs_req),
        .csr_rsp      (csr_rsp),
        .prbs_rsp     (prbs_rsp),
        .unmapped_evt (unmapped_evt)
    );

    // header, id, error and scratch registers
    csr_afu csr_i (
        .clk          (clk),
        .reset        (reset),
        .req          (csr_req),
        .rsp          (csr_rsp),
        .unmapped_evt (unmapped_evt),
        .mismatch_evt (mismatch_evt)
    );

    // loopback pattern test
    prbs_engine prbs_i (
        .clk          (clk),
        .reset        (reset),
        .req          (prbs_req),
        .rsp          (prbs_rsp),
        .mismatch_evt (mismatch_evt)
    );

endmodule

`default_nettype wire

// File: csr_afu.sv
`timescale 1ns/1ps
`default_nettype none

`include "afu_macros.svh"

module csr_afu (
    input  logic                    clk,
    input  logic                    reset,
    input  mmio_afu_pkg::mmio_req_t req,
    output mmio_afu_pkg::mmio_rsp_t rsp,
    input  logic                    unmapped_evt,
    input  logic                    mismatch_evt
);
    import mmio_afu_pkg::*;

    localparam logic [127:0] afu_id = `AFU_ID;

    // register offsets inside the csr window
    localparam logic [`MMIO_ADDR_W-1:0] off_dfh     = `AFU_DFH - `CSR_BASE;
    localparam logic [`MMIO_ADDR_W-1:0] off_id_l    = `ID_L - `CSR_BASE;
    localparam logic [`MMIO_ADDR_W-1:0] off_id_h    = `ID_H - `CSR_BASE;
    localparam logic [`MMIO_ADDR_W-1:0] off_rsvd    = `DFH_RSVD - `CSR_BASE;
    localparam logic [`MMIO_ADDR_W-1:0] off_error   = `ERROR - `CSR_BASE;
    localparam logic [`MMIO_ADDR_W-1:0] off_scratch = `SCRATCH - `CSR_BASE;

    dfh_word_u               dfh;
    logic [`MMIO_DATA_W-1:0] scratch_q;
    logic [1:0]              error_q;     // [1] prbs mismatch, [0] unmapped access
    logic [1:0]              error_clr;
    logic                    scratch_wr;
    logic [`MMIO_DATA_W-1:0] rd_data;

    // afu header, only type and next offset are nonzero
    always_comb begin
        dfh.raw                 = '0;
        dfh.fields.feature_type = 4'h1; // afu
        dfh.fields.eol          = 1'b0;
        dfh.fields.next_offset  = `DFH_NEXT_OFFSET;
    end

    assign scratch_wr = req.wr && (req.addr == off_scratch);

    // write one to clear, low byte carries the bits
    always_comb begin
        error_clr = 2'b00;
        if (req.wr && (req.addr == off_error) && req.be[0]) begin
            error_clr = req.wdata[1:0];
        end
    end

    always_comb begin
        case (req.addr)
            off_dfh:     rd_data = dfh.raw;
            off_id_l:    rd_data = afu_id[63:0];
            off_id_h:    rd_data = afu_id[127:64];
            off_rsvd:    rd_data = '0;
            off_error:   rd_data = {{(`MMIO_DATA_W-2){1'b0}}, error_q};
            off_scratch: rd_data = scratch_q;
            default:     rd_data = '0; // holes in the window
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            error_q <= 2'b00;
        end else begin
            // a new event wins over a clear in the same cycle
            error_q <= (error_q & ~error_clr) | {mismatch_evt, unmapped_evt};
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            scratch_q <= '0;
        end else if (scratch_wr) begin
            for (int b = 0; b < `MMIO_BE_W; b++) begin
                if (req.be[b]) begin
                    scratch_q[8*b +: 8] <= req.wdata[8*b +: 8];
                end
            end
        end
    end

    // one cycle read latency
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rsp <= '0;
        end else begin
            rsp.valid <= req.rd;
            if (req.rd) begin
                rsp.data <= rd_data;
            end
        end
    end

    // every response traces back to a routed read strobe
    a_rsp_after_rd: assert property (
        @(posedge clk) disable iff (reset)
        rsp.valid |-> $past(req.rd)
    );

endmodule

`default_nettype wire

// File: mmio_afu.f
+incdir+.
mmio_afu_pkg.sv
mmio_fabric.sv
csr_afu.sv
prbs_engine.sv
afu_top.sv
tb_afu_top.sv

// File: mmio_afu_pkg.sv
`default_nettype none

`include "afu_macros.svh"

package mmio_afu_pkg;

    // one host access, strobes are single cycle
    typedef struct packed {
        logic                    rd;
        logic                    wr;
        logic [`MMIO_ADDR_W-1:0] addr;
        logic [`MMIO_DATA_W-1:0] wdata;
        logic [`MMIO_BE_W-1:0]   be;
    } mmio_req_t;

    // read return, data only meaningful with valid
    typedef struct packed {
        logic                    valid;
        logic [`MMIO_DATA_W-1:0] data;
    } mmio_rsp_t;

    // device feature header layout, msb first
    typedef struct packed {
        logic [3:0]  feature_type;
        logic [7:0]  rsvd_hi;
        logic [3:0]  minor_rev;
        logic [6:0]  rsvd_lo;
        logic        eol;          // end of feature list
        logic [23:0] next_offset;
        logic [3:0]  major_rev;
        logic [11:0] feature_id;
    } dfh_fields_t;

    // header seen as a bus word or as its fields
    typedef union packed {
        logic [`MMIO_DATA_W-1:0] raw;
        dfh_fields_t             fields;
    } dfh_word_u;

endpackage

`default_nettype wire

// File: mmio_fabric.sv
`timescale 1ns/1ps
`default_nettype none

`include "afu_macros.svh"

module mmio_fabric (
    input  logic                    clk,
    input  logic                    reset,
    input  mmio_afu_pkg::mmio_req_t host_req,
    output mmio_afu_pkg::mmio_rsp_t host_rsp,
    output mmio_afu_pkg::mmio_req_t csr_req,
    output mmio_afu_pkg::mmio_req_t prbs_req,
    input  mmio_afu_pkg::mmio_rsp_t csr_rsp,
    input  mmio_afu_pkg::mmio_rsp_t prbs_rsp,
    output logic                    unmapped_evt
);
    import mmio_afu_pkg::*;

    logic                    hit_csr;
    logic                    hit_prbs;
    logic                    hit_none;
    logic                    unmapped_rd_q;
    logic [`MMIO_DATA_W-1:0] csr_data;
    logic [`MMIO_DATA_W-1:0] prbs_data;
    mmio_rsp_t               merged;

    // window decode, done once for both strobes
    assign hit_csr  = (host_req.addr >= `CSR_BASE) && (host_req.addr <= `CSR_LAST);
    assign hit_prbs = (host_req.addr >= `PRBS_BASE) && (host_req.addr <= `PRBS_LAST);
    assign hit_none = !hit_csr && !hit_prbs;

    // blocks see their own offset, strobes only on a hit
    always_comb begin
        csr_req      = host_req;
        csr_req.rd   = host_req.rd & hit_csr;
        csr_req.wr   = host_req.wr & hit_csr;
        csr_req.addr = host_req.addr - `CSR_BASE;

        prbs_req      = host_req;
        prbs_req.rd   = host_req.rd & hit_prbs;
        prbs_req.wr   = host_req.wr & hit_prbs;
        prbs_req.addr = host_req.addr - `PRBS_BASE;
    end

    // block data only counts while its valid is up
    assign csr_data  = csr_rsp.data & {`MMIO_DATA_W{csr_rsp.valid}};
    assign prbs_data = prbs_rsp.data & {`MMIO_DATA_W{prbs_rsp.valid}};

    always_comb begin
        merged.valid = csr_rsp.valid | prbs_rsp.valid | unmapped_rd_q;
        merged.data  = csr_data | prbs_data; // unmapped read adds nothing, so zero
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            unmapped_rd_q <= 1'b0;
            unmapped_evt  <= 1'b0;
            host_rsp      <= '0;
        end else begin
            // same stage as the block response registers
            unmapped_rd_q <= host_req.rd & hit_none;
            unmapped_evt  <= (host_req.rd | host_req.wr) & hit_none;
            host_rsp      <= merged;
        end
    end

    // host contract, one kind of access per cycle
    a_no_rd_wr_overlap: assert property (
        @(posedge clk) disable iff (reset)
        !(host_req.rd && host_req.wr)
    );

    // decode keeps the two block returns apart, so the OR merge is safe
    a_one_block_rsp: assert property (
        @(posedge clk) disable iff (reset)
        !(csr_rsp.valid && prbs_rsp.valid)
    );

endmodule

`default_nettype wire

// File: prbs_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "afu_macros.svh"

module prbs_engine (
    input  logic                    clk,
    input  logic                    reset,
    input  mmio_afu_pkg::mmio_req_t req,
    output mmio_afu_pkg::mmio_rsp_t rsp,
    output logic                    mismatch_evt
);
    localparam int prbs_w = 31;
    localparam int step_w = prbs_w + `MMIO_DATA_W; // {next state, word}
    localparam logic [prbs_w-1:0] prbs_seed = 31'h7fffffff; // any nonzero state

    localparam logic [`MMIO_ADDR_W-1:0] off_ctrl  = `PRBS_CTRL - `PRBS_BASE;
    localparam logic [`MMIO_ADDR_W-1:0] off_words = `PRBS_WORDS - `PRBS_BASE;
    localparam logic [`MMIO_ADDR_W-1:0] off_errs  = `PRBS_ERRS - `PRBS_BASE;

    logic                    enable_q;
    logic                    inject_pend_q;
    logic [prbs_w-1:0]       gen_state_q;
    logic [prbs_w-1:0]       chk_state_q;
    logic [`MMIO_DATA_W-1:0] loop_q;       // loopback word under test
    logic                    loop_vld_q;
    logic [`MMIO_DATA_W-1:0] words_q;
    logic [`MMIO_DATA_W-1:0] errs_q;
    logic [step_w-1:0]       gen_next;
    logic [step_w-1:0]       chk_next;
    logic                    ctrl_wr;
    logic                    clr_cnt;
    logic                    mismatch;
    logic [`MMIO_DATA_W-1:0] rd_data;

    // x^31 + x^28 + 1, 64 serial steps per word, msb first
    function automatic logic [step_w-1:0] prbs_advance(input logic [prbs_w-1:0] state);
        logic [prbs_w-1:0]       s;
        logic [`MMIO_DATA_W-1:0] word;
        logic                    fb;
        s = state;
        for (int i = `MMIO_DATA_W - 1; i >= 0; i--) begin
            fb      = s[30] ^ s[27];
            word[i] = fb;
            s       = {s[prbs_w-2:0], fb};
        end
        return {s, word};
    endfunction

    assign ctrl_wr  = req.wr && (req.addr == off_ctrl) && req.be[0];
    assign clr_cnt  = ctrl_wr && req.wdata[2];
    assign gen_next = prbs_advance(gen_state_q);
    assign chk_next = prbs_advance(chk_state_q);
    assign mismatch = loop_vld_q && (loop_q != chk_next[`MMIO_DATA_W-1:0]);

    // generator side
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            enable_q      <= 1'b0;
            inject_pend_q <= 1'b0;
            gen_state_q   <= prbs_seed;
            loop_q        <= '0;
            loop_vld_q    <= 1'b0;
        end else begin
            if (ctrl_wr) begin
                enable_q <= req.wdata[0];
            end
            loop_vld_q <= enable_q;
            if (enable_q) begin
                gen_state_q <= gen_next[step_w-1:`MMIO_DATA_W];
                loop_q      <= gen_next[`MMIO_DATA_W-1:0] ^
                               {{(`MMIO_DATA_W-1){1'b0}}, inject_pend_q}; // flip bit 0
            end
            if (ctrl_wr && req.wdata[1]) begin
                inject_pend_q <= 1'b1;
            end else if (enable_q) begin
                inject_pend_q <= 1'b0; // consumed by this word
            end
        end
    end

    // checker side, own sequence copy steps once per received word
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            chk_state_q  <= prbs_seed;
            words_q      <= '0;
            errs_q       <= '0;
            mismatch_evt <= 1'b0;
        end else begin
            if (loop_vld_q) begin
                chk_state_q <= chk_next[step_w-1:`MMIO_DATA_W];
            end
            mismatch_evt <= mismatch;
            if (clr_cnt) begin
                words_q <= '0;
                errs_q  <= '0;
            end else if (loop_vld_q) begin
                words_q <= words_q + 1'b1;
                if (mismatch) begin
                    errs_q <= errs_q + 1'b1;
                end
            end
        end
    end

    always_comb begin
        case (req.addr)
            off_ctrl:  rd_data = {{(`MMIO_DATA_W-1){1'b0}}, enable_q};
            off_words: rd_data = words_q;
            off_errs:  rd_data = errs_q;
            default:   rd_data = '0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rsp <= '0;
        end else begin
            rsp.valid <= req.rd;
            if (req.rd) begin
                rsp.data <= rd_data;
            end
        end
    end

    // error count only moves up until software clears it
    a_errs_monotonic: assert property (
        @(posedge clk) disable iff (reset)
        !$past(clr_cnt) |-> (errs_q >= $past(errs_q))
    );

endmodule

`default_nettype wire

// File: tb_afu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "afu_macros.svh"

module tb_afu_top;
    import mmio_afu_pkg::*;

    typedef struct packed {
        logic                    check;   // low means capture only
        logic [`MMIO_DATA_W-1:0] data;
    } expect_t;

    localparam logic [127:0] afu_id = `AFU_ID;

    logic                    clk;
    logic                    reset;
    mmio_req_t               mmio_req;
    mmio_rsp_t               mmio_rsp;
    expect_t                 exp_q[$];   // one entry per read in flight
    expect_t                 head;
    string                   test_name;
    int unsigned             accesses;
    int unsigned             reads_issued;
    int unsigned             rsp_count;
    int unsigned             cycles;
    int unsigned             k;
    logic [`MMIO_DATA_W-1:0] last_rdata;
    logic [`MMIO_DATA_W-1:0] scratch_model;
    logic [`MMIO_DATA_W-1:0] words_a;
    logic [`MMIO_DATA_W-1:0] words_b;
    logic [`MMIO_DATA_W-1:0] wdata;
    logic [`MMIO_BE_W-1:0]   be;
    logic [`MMIO_ADDR_W-1:0] bad_addr;
    dfh_word_u               dfh;

    afu_top dut_i (
        .clk      (clk),
        .reset    (reset),
        .mmio_req (mmio_req),
        .mmio_rsp (mmio_rsp)
    );

    always #5 clk = ~clk;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input logic [63:0] exp, input logic [63:0] act);
        stop_run($sformatf("FAILED %s: expected %h, actual %h", test_name, exp, act));
    endtask

    // byte lanes with their enable set take the new data
    function automatic logic [63:0] merge_bytes(input logic [63:0] old,
                                                input logic [63:0] data,
                                                input logic [7:0]  en);
        logic [63:0] r;
        r = old;
        for (int b = 0; b < 8; b++) begin
            if (en[b]) begin
                r[8*b +: 8] = data[8*b +: 8];
            end
        end
        return r;
    endfunction

    task automatic issue_read(input logic [17:0] addr, input logic check,
                              input logic [63:0] exp);
        mmio_req_t r;
        r      = '0;
        r.rd   = 1'b1;
        r.addr = addr;
        r.be   = '1;
        @(posedge clk);
        mmio_req <= r;
        exp_q.push_back({check, exp});
        reads_issued++;
        accesses++;
    endtask

    task automatic issue_write(input logic [17:0] addr, input logic [63:0] data,
                               input logic [7:0] en);
        mmio_req_t r;
        r       = '0;
        r.wr    = 1'b1;
        r.addr  = addr;
        r.wdata = data;
        r.be    = en;
        @(posedge clk);
        mmio_req <= r;
        accesses++;
    endtask

    task automatic bus_idle(input int n);
        repeat (n) begin
            @(posedge clk);
            mmio_req <= '0;
        end
    endtask

    task automatic wait_responses();
        while (rsp_count != reads_issued) @(posedge clk); // watchdog bounds this
    endtask

    task automatic read_check(input logic [17:0] addr, input logic [63:0] exp);
        issue_read(addr, 1'b1, exp);
        bus_idle(1);
        wait_responses();
    endtask

    task automatic read_value(input logic [17:0] addr, output logic [63:0] value);
        issue_read(addr, 1'b0, '0);
        bus_idle(1);
        wait_responses();
        value = last_rdata;
    endtask

    task automatic write_reg(input logic [17:0] addr, input logic [63:0] data,
                             input logic [7:0] en);
        issue_write(addr, data, en);
        bus_idle(1);
    endtask

    // read returns exactly two cycles after its strobe
    a_rsp_timing: assert property (
        @(posedge clk) disable iff (reset)
        mmio_rsp.valid == $past(mmio_req.rd, 2)
    ) else stop_run("read response valid did not follow a read strobe by two cycles");

    // sampled mid cycle away from the edge
    always @(negedge clk) begin
        if (!reset && mmio_rsp.valid) begin
            a_rsp_expected: assert (exp_q.size() > 0)
                else stop_run("read response arrived with no read outstanding");
            head = exp_q.pop_front();
            if (head.check) begin
                a_rsp_data: assert (mmio_rsp.data == head.data)
                    else report_mismatch(head.data, mmio_rsp.data);
            end
            last_rdata = mmio_rsp.data;
            rsp_count++;
        end
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > accesses * 20 + 2000) begin
                stop_run("timeout, the test sequence did not finish in time");
            end
        end
    end

    initial begin
        clk           = 1'b0;
        reset         = 1'b1;
        mmio_req      = '0;
        accesses      = 0;
        reads_issued  = 0;
        rsp_count     = 0;
        last_rdata    = '0;
        scratch_model = '0;
        void'($urandom(32'ha07b));
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        bus_idle(2);

        test_name = "dfh_header";
        read_value(`AFU_DFH, dfh.raw);
        a_dfh_type: assert (dfh.fields.feature_type == 4'h1)
            else report_mismatch(64'h1, 64'(dfh.fields.feature_type));
        a_dfh_next: assert (dfh.fields.next_offset == `DFH_NEXT_OFFSET)
            else report_mismatch(64'(`DFH_NEXT_OFFSET), 64'(dfh.fields.next_offset));
        dfh.fields.feature_type = '0;
        dfh.fields.next_offset  = '0;
        a_dfh_rest: assert (dfh.raw == '0) else report_mismatch('0, dfh.raw); // rest is zero
        read_check(`ID_L, afu_id[63:0]);
        read_check(`ID_H, afu_id[127:64]);
        read_check(`DFH_RSVD, '0);

        test_name = "scratch_merge";
        for (int i = 0; i < 8; i++) begin
            wdata         = {$urandom(), $urandom()};
            be            = 8'($urandom());
            scratch_model = merge_bytes(scratch_model, wdata, be);
            issue_write(`SCRATCH, wdata, be);
            issue_read(`SCRATCH, 1'b1, scratch_model); // read right behind the write
            bus_idle(1);
            wait_responses();
        end
        issue_read(`SCRATCH, 1'b1, scratch_model);
        issue_read(`ID_L, 1'b1, afu_id[63:0]);
        issue_read(`ERROR, 1'b1, '0);
        issue_read(`SCRATCH, 1'b1, scratch_model);
        bus_idle(1);
        wait_responses();

        test_name = "unmapped";
        bad_addr = 18'(32'h40 + ($urandom() % 32'h3ffc0));
        read_check(bad_addr, '0);
        bus_idle(2);
        read_check(`ERROR, 64'h1);
        write_reg(`ERROR, 64'h1, 8'h01);
        read_check(`ERROR, 64'h0);
        bad_addr = 18'(32'h40 + ($urandom() % 32'h3ffc0));
        write_reg(bad_addr, {$urandom(), $urandom()}, 8'hff);
        bus_idle(2);
        read_check(`ERROR, 64'h1);
        write_reg(`ERROR, 64'h1, 8'h01);
        read_check(`ERROR, 64'h0);

        test_name = "prbs_run";
        write_reg(`PRBS_CTRL, 64'h5, 8'h01);  // clear and enable
        read_check(`PRBS_CTRL, 64'h1);
        bus_idle(50);
        read_value(`PRBS_WORDS, words_a);
        a_words_nonzero: assert (words_a != '0)
            else stop_run("PRBS word counter stayed at zero while enabled");
        bus_idle(10);
        read_value(`PRBS_WORDS, words_b);
        a_words_rising: assert (words_b > words_a)
            else stop_run("PRBS word counter did not increase while enabled");
        read_check(`PRBS_ERRS, '0);

        test_name = "prbs_inject";
        k = 1 + ($urandom() % 5);
        repeat (k) begin
            write_reg(`PRBS_CTRL, 64'h3, 8'h01);
            bus_idle(4);
        end
        read_check(`PRBS_ERRS, 64'(k));
        read_check(`ERROR, 64'h2);
        write_reg(`PRBS_CTRL, 64'h0, 8'h01);
        bus_idle(4);                           // let the last word drain
        write_reg(`PRBS_CTRL, 64'h4, 8'h01);
        read_check(`PRBS_WORDS, '0);
        read_check(`PRBS_ERRS, '0);
        bus_idle(10);
        read_check(`PRBS_WORDS, '0);
        read_check(`PRBS_CTRL, '0);

        wait_responses();
        bus_idle(3);
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire
